// ==== compile.f ====
rtl/fetch_pkg.sv
rtl/instr_mem.sv
rtl/fetch_unit.sv
rtl/branch_target.sv
rtl/front_end_top.sv
verif/front_end_tb.sv

// ==== rtl/branch_target.sv ====
`timescale 1ns/1ps

module branch_target (
    input  fetch_pkg::if_id_t    if_id,
    input  fetch_pkg::redirect_t redirect,
    output logic                 redirect_valid,
    output logic [31:0]          redirect_pc
);
    import fetch_pkg::*;

    logic [31:0] branch_off;
    logic [31:0] index_pc;

    // Word offset from the 16-bit immediate
    assign branch_off = {{14{if_id.instr[15]}}, if_id.instr[15:0], 2'b00};

    // Jump stays inside the 256 MB region of the delay slot
    assign index_pc = {if_id.nextpc[31:28], if_id.instr[25:0], 2'b00};

    always_comb begin
        case (redirect.kind)
            REDIR_BRANCH:   redirect_pc = if_id.nextpc + branch_off;
            REDIR_REGISTER: redirect_pc = redirect.rega;
            REDIR_INDEX:    redirect_pc = index_pc;
            REDIR_VECTOR:   redirect_pc = EXC_VECTOR;
            default:        redirect_pc = EXC_VECTOR;
        endcase
    end

    assign redirect_valid = redirect.take && if_id.valid;   // Only a delivered instruction redirects

endmodule

// ==== rtl/fetch_pkg.sv ====
package fetch_pkg;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    // Wishbone classic, slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;                      // Address the instruction came from
        logic [31:0] nextpc;                  // Always pc + 4
        logic [31:0] instr;
    } if_id_t;

    // Same encoding as the decode PC-type selector
    typedef enum logic [1:0] {
        REDIR_BRANCH   = 2'b00,
        REDIR_REGISTER = 2'b01,
        REDIR_INDEX    = 2'b10,
        REDIR_VECTOR   = 2'b11
    } redir_kind_e;

    typedef struct packed {
        logic        take;
        redir_kind_e kind;
        logic [31:0] rega;                    // Source register value for register jumps
    } redirect_t;

    localparam logic [31:0] RESET_PC   = 32'h0000_0000;
    localparam logic [31:0] EXC_VECTOR = 32'h0000_0040;

endpackage

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic               clock,
    input  logic               reset,
    input  logic               stall,
    output fetch_pkg::wb_req_t wb_req,
    input  fetch_pkg::wb_rsp_t wb_rsp,
    input  logic               redirect_valid,
    input  logic [31:0]        redirect_pc,
    output fetch_pkg::if_id_t  if_id
);
    import fetch_pkg::*;

    typedef enum logic {
        BUS_IDLE,
        BUS_WAIT
    } bus_state_e;

    bus_state_e  state;
    logic [31:0] pc;
    logic [31:0] fetch_adr;
    logic        squash;
    logic        start;
    logic        accept;
    logic        deliver;
    logic        squash_set;
    logic        slot_valid;
    logic [31:0] slot_pc;
    logic [31:0] slot_instr;

    assign start      = (state == BUS_IDLE) && !stall;
    assign accept     = (state == BUS_WAIT) && wb_rsp.ack && !squash;
    assign deliver    = slot_valid && !stall;
    assign squash_set = redirect_valid && (start || ((state == BUS_WAIT) && !wb_rsp.ack));

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state      <= BUS_IDLE;
            pc         <= RESET_PC;
            squash     <= 1'b0;
            slot_valid <= 1'b0;
        end else begin
            case (state)
                BUS_IDLE: begin
                    if (start) begin
                        state <= BUS_WAIT;
                    end
                end
                BUS_WAIT: begin
                    if (wb_rsp.ack) begin
                        state <= BUS_IDLE;             // cyc and stb drop after ack
                    end
                end
                default: state <= BUS_IDLE;
            endcase

            if (redirect_valid) begin
                pc <= redirect_pc;
            end else if (start) begin
                pc <= pc + 32'd4;
            end

            // The fetch on the bus at redirect time belongs to the old path
            if (squash_set) begin
                squash <= 1'b1;
            end else if ((state == BUS_WAIT) && wb_rsp.ack) begin
                squash <= 1'b0;
            end

            if (accept) begin
                slot_valid <= 1'b1;
            end else if (deliver) begin
                slot_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            fetch_adr <= pc;
        end
        if (accept) begin
            slot_pc    <= fetch_adr;
            slot_instr <= wb_rsp.dat;
        end
    end

    assign wb_req.cyc = (state == BUS_WAIT);
    assign wb_req.stb = (state == BUS_WAIT);
    assign wb_req.we  = 1'b0;
    assign wb_req.adr = fetch_adr;
    assign wb_req.dat = 32'h0000_0000;

    // The IF/ID register also serves as the pending slot while stalled
    always_comb begin
        if_id.valid  = deliver;
        if_id.pc     = slot_pc;
        if_id.nextpc = slot_pc + 32'd4;
        if_id.instr  = slot_instr;
    end

    a_req_stable: assert property (
        @(posedge clock) disable iff (!reset)
        (wb_req.stb && !wb_rsp.ack) |=> (wb_req.stb && $stable(wb_req.adr))
    ) else $error("fetch_unit: request changed before ack");

    // Covers the redirect cycle and the whole squashed fetch up to its ack
    a_no_wrong_path: assert property (
        @(posedge clock) disable iff (!reset)
        (redirect_valid || squash) |=> !if_id.valid
    ) else $error("fetch_unit: delivery right after a redirect");

endmodule

// ==== rtl/front_end_top.sv ====
`timescale 1ns/1ps

module front_end_top #(
    parameter int MEM_WORDS   = 128,
    parameter int WAIT_STATES = 1
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         stall,
    input  fetch_pkg::redirect_t         redirect,
    input  logic                         load_en,
    input  logic [$clog2(MEM_WORDS)-1:0] load_addr,
    input  logic [31:0]                  load_data,
    output fetch_pkg::if_id_t            if_id,
    output logic                         bus_cyc
);
    import fetch_pkg::*;

    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    assign bus_cyc = wb_req.cyc;

    instr_mem #(
        .MEM_WORDS   (MEM_WORDS),
        .WAIT_STATES (WAIT_STATES)
    ) u_mem (
        .clock     (clock),
        .reset     (reset),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    fetch_unit u_fetch (
        .clock          (clock),
        .reset          (reset),
        .stall          (stall),
        .wb_req         (wb_req),
        .wb_rsp         (wb_rsp),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .if_id          (if_id)
    );

    branch_target u_target (
        .if_id          (if_id),
        .redirect       (redirect),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

// ==== rtl/instr_mem.sv ====
`timescale 1ns/1ps

module instr_mem #(
    parameter int MEM_WORDS   = 128,
    parameter int WAIT_STATES = 1
) (
    input  logic                         clock,
    input  logic                         reset,
    input  fetch_pkg::wb_req_t           wb_req,
    output fetch_pkg::wb_rsp_t           wb_rsp,
    input  logic                         load_en,
    input  logic [$clog2(MEM_WORDS)-1:0] load_addr,
    input  logic [31:0]                  load_data
);
    import fetch_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    logic [31:0]   mem [MEM_WORDS];
    logic [31:0]   rd_data;
    logic [AW-1:0] word_idx;
    logic [1:0]    wait_cnt;
    logic          ack;
    logic          active;
    logic          done;

    assign word_idx = wb_req.adr[AW+1:2];              // Byte address to word index
    assign active   = wb_req.cyc && wb_req.stb && !ack;
    assign done     = active && (wait_cnt == 2'(WAIT_STATES));

    // Count wait states while a request is outstanding
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wait_cnt <= 2'd0;
            ack      <= 1'b0;
        end else begin
            ack <= done;                               // Single-cycle ack
            if (active && !done) begin
                wait_cnt <= wait_cnt + 2'd1;
            end else begin
                wait_cnt <= 2'd0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end else if (done && wb_req.we) begin
            mem[word_idx] <= wb_req.dat;
        end
        if (done) begin
            rd_data <= mem[word_idx];                  // Read data lines up with ack
        end
    end

    assign wb_rsp.ack = ack;
    assign wb_rsp.dat = rd_data;

    a_ack_needs_stb: assert property (
        @(posedge clock) disable iff (!reset)
        wb_rsp.ack |-> wb_req.stb
    ) else $error("instr_mem: ack without an active strobe");

    a_no_load_on_bus: assert property (
        @(posedge clock) disable iff (!reset)
        load_en |-> !wb_req.cyc
    ) else $error("instr_mem: load_en while a bus cycle is active");

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module front_end_tb -f compile.f -o front_end_sim &&
./obj_dir/front_end_sim ||
exit 1

// ==== verif/fetch_patterns.hex ====
// Words 0-127: instruction memory image, eight words per line, starting at word 0
// Words 128-136: script words oooo t k rr (delivery ordinal, take, kind, rega), ffff ends, then load word
24080000 24080004 24080008 2408000c 24080010 24080014 24080018 2408001c
24080020 24080024 24080028 2408002c 24080030 24080034 24080038 2408003c
24080040 24080044 1000fff0 2408004c 10000008 24080054 24080058 2408005c
24080060 24080064 24080068 2408006c 24080070 24080074 24080078 2408007c
24080080 24080084 24080088 2408008c 24080090 24080094 24080098 2408009c
240800a0 08000030 240800a8 240800ac 240800b0 240800b4 240800b8 240800bc
240800c0 240800c4 240800c8 240800cc 240800d0 240800d4 240800d8 240800dc
240800e0 240800e4 240800e8 240800ec 240800f0 240800f4 240800f8 240800fc
24080100 24080104 24080108 2408010c 24080110 24080114 24080118 2408011c
24080120 24080124 24080128 2408012c 24080130 24080134 24080138 2408013c
24080140 24080144 24080148 2408014c 24080150 24080154 24080158 2408015c
24080160 24080164 24080168 2408016c 24080170 24080174 24080178 2408017c
24080180 24080184 24080188 2408018c 24080190 24080194 24080198 2408019c
240801a0 240801a4 240801a8 240801ac 240801b0 240801b4 240801b8 240801bc
240801c0 240801c4 240801c8 240801cc 240801d0 240801d4 240801d8 240801dc
240801e0 240801e4 240801e8 240801ec 240801f0 240801f4 240801f8 240801fc
00141000 001611a0 00181200 001b1300 001e1000 00230300 002811f0
ffff0000 3c0ade5a

// ==== verif/front_end_tb.sv ====
`timescale 1ns/1ps

module front_end_tb;
    import fetch_pkg::*;

    localparam int MEM_WORDS      = 128;
    localparam int SCRIPT_BASE    = MEM_WORDS;
    localparam int PATTERN_WORDS  = MEM_WORDS + 9;
    localparam int LOAD_WORD_IDX  = PATTERN_WORDS - 1;
    localparam int NUM_DELIVERIES = 48;
    localparam int TIMEOUT        = 200;

    logic        clock;
    logic        reset;
    logic        stall;
    redirect_t   redirect;
    logic        load_en;
    logic [6:0]  load_addr;
    logic [31:0] load_data;
    if_id_t      if_id;
    logic        bus_cyc;

    logic [31:0] patterns [PATTERN_WORDS];
    logic [31:0] ref_mem [MEM_WORDS];               // Reference copy of the instruction memory
    logic [31:0] ref_pc;
    logic [31:0] lfsr_state;
    redirect_t   next_redirect;
    int          stall_left;
    bit          random_stall;

    front_end_top #(
        .MEM_WORDS   (MEM_WORDS),
        .WAIT_STATES (2)
    ) u_dut (
        .clock     (clock),
        .reset     (reset),
        .stall     (stall),
        .redirect  (redirect),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .if_id     (if_id),
        .bus_cyc   (bus_cyc)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic draw_bits(input int count, output int value);
        value = 0;
        for (int b = 0; b < count; b++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // Next PC after a taken redirect, worked out from the delivered word
    function automatic logic [31:0] expected_target(input redir_kind_e kind,
            input logic [31:0] instr, input logic [31:0] nextpc, input logic [31:0] rega);
        logic signed [31:0] offset;
        logic [31:0]        target;
        offset = 32'(signed'(instr[15:0]));
        case (kind)
            REDIR_BRANCH:   target = nextpc + (offset <<< 2);
            REDIR_REGISTER: target = rega;
            REDIR_INDEX:    target = (nextpc & 32'hf000_0000) | {4'd0, instr[25:0], 2'b00};
            default:        target = 32'h0000_0040;
        endcase
        return target;
    endfunction

    task automatic end_with_failure(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        assert (actual === expected) else begin
            end_with_failure($sformatf("[FAIL] %s: expected %h, actual %h",
                                       name, expected, actual));
        end
    endtask

    task automatic check_delivery(input string name);
        check_equal({name, " pc"}, ref_pc, if_id.pc);
        check_equal({name, " nextpc"}, ref_pc + 32'd4, if_id.nextpc);
        check_equal({name, " instr"}, ref_mem[ref_pc[8:2]], if_id.instr);
    endtask

    task automatic load_word(input logic [6:0] addr, input logic [31:0] data);
        @(posedge clock);
        load_en   <= 1'b1;
        load_addr <= addr;
        load_data <= data;
    endtask

    // Runs cycles until the next delivery, with random stalls unless they are off
    task automatic wait_delivery();
        int  cycles;
        int  draw;
        bit  delivered;
        cycles    = 0;
        delivered = 0;
        while (!delivered) begin
            @(posedge clock);
            redirect <= next_redirect;
            if (!random_stall) begin
                stall <= 1'b0;
            end else if (stall_left > 0) begin
                stall      <= 1'b1;
                stall_left = stall_left - 1;
            end else begin
                stall <= 1'b0;
                draw_bits(3, draw);
                if (draw == 0) begin
                    draw_bits(3, stall_left);               // Stall of 0 to 7 cycles
                end
            end
            @(negedge clock);
            if (stall) begin
                check_equal("stall_hold valid", 32'd0, 32'(if_id.valid));
            end
            delivered = if_id.valid;
            cycles++;
            if (!delivered && cycles >= TIMEOUT) begin
                end_with_failure("Timeout: no instruction was delivered within 200 cycles");
            end
        end
    endtask

    initial begin
        int          i;
        int          si;
        int          cycles;
        logic [31:0] entry;
        logic [31:0] new_word;
        logic [6:0]  next_word;
        bit          took;
        string       name;

        reset         = 1'b0;
        stall         = 1'b1;                           // Keeps the bus idle while the image loads
        redirect      = '0;
        load_en       = 1'b0;
        load_addr     = '0;
        load_data     = '0;
        next_redirect = '0;
        stall_left    = 0;
        random_stall  = 1;
        lfsr_state    = 32'hcc05;
        $readmemh("verif/fetch_patterns.hex", patterns);
        for (i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = patterns[i];
        end
        ref_pc = RESET_PC;

        repeat (8) @(posedge clock);
        reset <= 1'b1;
        for (i = 0; i < MEM_WORDS; i++) begin
            load_word(7'(i), patterns[i]);
            @(negedge clock);
            check_equal("reset_state valid", 32'd0, 32'(if_id.valid));
            check_equal("reset_state bus_cyc", 32'd0, 32'(bus_cyc));
        end
        @(posedge clock);
        load_en <= 1'b0;

        si   = 0;
        took = 0;
        for (int ord = 0; ord < NUM_DELIVERIES; ord++) begin
            entry         = patterns[SCRIPT_BASE + si];
            next_redirect = '0;
            if (int'(entry[31:16]) == ord) begin
                next_redirect.take = entry[12];
                next_redirect.kind = redir_kind_e'(entry[9:8]);
                next_redirect.rega = {24'd0, entry[7:0]};
                si++;
            end
            if (ord < 20) begin
                name = "sequential_fetch";
            end else if (took) begin
                name = "redirect";
            end else begin
                name = "stall_stream";
            end
            wait_delivery();
            if (ord < 20) begin
                check_equal("sequential_fetch order", 32'(ord * 4), if_id.pc);
            end
            check_delivery(name);
            took = next_redirect.take;
            if (took) begin
                ref_pc = expected_target(next_redirect.kind, ref_mem[ref_pc[8:2]],
                                         ref_pc + 32'd4, next_redirect.rega);
            end else begin
                ref_pc = ref_pc + 32'd4;
            end
        end

        // Hold stall until the in-flight fetch lands in the pending slot
        random_stall  = 0;
        next_redirect = '0;
        @(posedge clock);
        stall    <= 1'b1;
        redirect <= '0;
        cycles = 0;
        @(negedge clock);
        while (bus_cyc) begin
            @(negedge clock);
            cycles++;
            if (cycles >= TIMEOUT) begin
                end_with_failure("Timeout: the bus cycle did not end while stalled");
            end
        end
        next_word = ref_pc[8:2] + 7'd1;
        new_word  = patterns[LOAD_WORD_IDX];
        load_word(next_word, new_word);
        ref_mem[next_word] = new_word;
        @(posedge clock);
        load_en <= 1'b0;

        wait_delivery();
        check_delivery("load_port pending");
        ref_pc = ref_pc + 32'd4;
        wait_delivery();
        check_delivery("load_port");
        check_equal("load_port new word", new_word, if_id.instr);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
